// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module tiny32_tb -f sim.f -o tiny32_sim \
    && ./obj_dir/tiny32_sim > sim.log 2>&1 \
    || { echo "Build or run failed"; exit 1; }
grep -q "^=== PASS ===$" sim.log && echo "Simulation passed" \
    || { cat sim.log; echo "Simulation failed"; exit 1; }

// File: sim.f
source/tiny32_pkg.sv
source/tiny32_decoder.sv
source/tiny32_regfile.sv
source/tiny32_execute.sv
source/tiny32_sequencer.sv
source/tiny32_bus_unit.sv
source/tiny32.sv
sim/tiny32_tb.sv

// File: sim/tiny32_tb.sv
module tiny32_tb;
    import tiny32_pkg::*;

    localparam logic [31:0] BASE_PC   = 32'h0000_0100;
    localparam logic [31:0] DATA_BASE = 32'h0000_0400;
    localparam int          STOP_WAIT = 5000;

    logic        main_clk;
    logic        nreset;
    logic        ready;
    logic [31:0] address;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic        nrd;
    logic [3:0]  nwr;
    logic        hlt;
    logic        error;

    logic [31:0] mem [0:1023];
    logic [31:0] rdy_state;
    logic [31:0] seed;
    logic        rand_ready;
    int          write_count;
    logic        bad_access;
    int          pidx;
    logic [11:0] st_off;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_val [$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          err_at_start;
    string       cur_test;

    tiny32 #(
        .RESET_PC (BASE_PC)
    ) u_tiny32 (
        .main_clk (main_clk),
        .nreset   (nreset),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .nrd      (nrd),
        .nwr      (nwr),
        .ready    (ready),
        .hlt      (hlt),
        .error    (error)
    );

    initial begin
        main_clk = 1'b0;
        forever #5 main_clk = ~main_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ******************** Memory model
    assign data_in = mem[address[11:2]];

    always @(posedge main_clk) begin
        if (rand_ready) begin
            rdy_state = lcg_next(rdy_state);
            ready <= rdy_state[16];
        end else begin
            ready <= 1'b1;
        end
    end

    always @(posedge main_clk) begin
        if (nreset && (!nrd || nwr != 4'hf) && address[1:0] != 2'b00) begin
            bad_access = 1'b1;
        end
        if (nreset && ready && nwr != 4'hf) begin
            write_count = write_count + 1;
            assert (nwr == 4'h0) else begin
                $display("ERROR %s: expected nwr %h, actual %h", cur_test, 4'h0, nwr);
                errors = errors + 1;
            end
            mem[address[11:2]] <= data_out;
        end
    end

    // ******************** Encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        enc_s = {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        enc_u = {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // RV32I reference rules
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    ref_alu = alt ? a - b : a + b;
            3'd1:    ref_alu = a << b[4:0];
            3'd2:    ref_alu = {31'b0, $signed(a) < $signed(b)};
            3'd3:    ref_alu = {31'b0, a < b};
            3'd4:    ref_alu = a ^ b;
            3'd5:    ref_alu = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    ref_alu = a | b;
            default: ref_alu = a & b;
        endcase
    endfunction

    function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0:    branch_rule = (a == b);
            3'd1:    branch_rule = (a != b);
            3'd4:    branch_rule = $signed(a) < $signed(b);
            3'd5:    branch_rule = $signed(a) >= $signed(b);
            3'd6:    branch_rule = a < b;
            default: branch_rule = a >= b;
        endcase
    endfunction

    function automatic logic [31:0] cur_pc();
        cur_pc = BASE_PC + 32'(4 * pidx);
    endfunction

    // ******************** Program helpers
    task automatic emit(input logic [31:0] w);
        mem[10'(64 + pidx)] = w;
        pidx = pidx + 1;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        emit(enc_u(hi[19:0], rd, OPC_LUI));
        emit(enc_i(v[11:0], rd, 3'd0, rd, OPC_OPIMM));
    endtask

    task automatic store_word(input logic [4:0] rs, input logic [31:0] v);
        emit(enc_s(st_off, rs, 5'd10));
        exp_addr.push_back(DATA_BASE + {20'b0, st_off});
        exp_val.push_back(v);
        st_off = st_off + 12'd4;
    endtask

    task automatic start_program();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;   // Address-dependent fill
        end
        pidx   = 0;
        st_off = 12'd0;
        exp_addr.delete();
        exp_val.delete();
        load_const(5'd10, DATA_BASE);
    endtask

    task automatic reset_dut();
        write_count = 0;
        bad_access  = 1'b0;
        @(posedge main_clk);
        nreset <= 1'b0;
        repeat (2) @(posedge main_clk);
        nreset <= 1'b1;
        @(posedge main_clk);
    endtask

    task automatic wait_stop();
        int n;
        n = 0;
        while (!(hlt || error) && n < STOP_WAIT) begin
            @(posedge main_clk);
            n = n + 1;
        end
        assert (hlt || error) else begin
            $display("%s: timed out waiting for the core to halt", cur_test);
            errors = errors + 1;
        end
    endtask

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", cur_test, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic check_words();
        @(posedge main_clk);
        check_value(32'(exp_addr.size()), 32'(write_count));
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_value(exp_val[i], mem[exp_addr[i][11:2]]);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = errors;
        tests_run    = tests_run + 1;
    endtask

    task automatic end_test();
        if (errors == err_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed with %0d errors", cur_test, errors - err_at_start);
        end
    endtask

    // ******************** Tests
    task automatic test_reset();
        int n;
        begin_test("reset");
        rand_ready = 1'b0;
        start_program();
        emit(enc_i(12'd0, 5'd0, FUNCT3_HALT, 5'd0, OPC_SYSTEM));
        reset_dut();
        check_value(32'd0, {30'b0, hlt, error});
        check_value(32'hf, {28'b0, nwr});
        n = 0;
        @(posedge main_clk);
        while (nrd && n < 20) begin
            @(posedge main_clk);
            n = n + 1;
        end
        assert (!nrd) else begin
            $display("%s: no read strobe seen after reset", cur_test);
            errors = errors + 1;
        end
        check_value(BASE_PC, address);
        wait_stop();
        end_test();
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [31:0] v;
        begin_test("alu");
        rand_ready = 1'b0;
        start_program();
        seed = lcg_next(seed);
        a = seed;
        seed = lcg_next(seed);
        b = seed;
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f3 != 0 && f3 != 5) continue;
                emit(enc_r((alt == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f3), 5'd3));
                store_word(5'd3, ref_alu(3'(f3), alt == 1, a, b));
                if (alt == 1 && f3 == 0) continue;   // No subi
                seed = lcg_next(seed);
                imm = seed[11:0];
                if (f3 == 1 || f3 == 5) imm = {(alt == 1) ? 7'h20 : 7'h00, seed[4:0]};
                emit(enc_i(imm, 5'd1, 3'(f3), 5'd3, OPC_OPIMM));
                store_word(5'd3, ref_alu(3'(f3), alt == 1, a, {{20{imm[11]}}, imm}));
            end
        end
        seed = lcg_next(seed);
        v = {seed[19:0], 12'h000};
        emit(enc_u(seed[19:0], 5'd4, OPC_LUI));
        store_word(5'd4, v);
        v = cur_pc() + {seed[19:0], 12'h000};
        emit(enc_u(seed[19:0], 5'd4, OPC_AUIPC));
        store_word(5'd4, v);
        emit(enc_i(12'd0, 5'd0, FUNCT3_HALT, 5'd0, OPC_SYSTEM));
        reset_dut();
        wait_stop();
        check_value(32'd1, {31'b0, hlt && !error});
        check_words();
        end_test();
    endtask

    task automatic test_branch();
        logic [31:0] regv [1:3];
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] link;
        logic [31:0] target;
        begin_test("branch");
        rand_ready = 1'b0;
        start_program();
        regv[1] = 32'd5;
        regv[2] = 32'hffff_fffd;
        regv[3] = 32'd5;
        for (int r = 1; r <= 3; r++) load_const(5'(r), regv[r]);
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) continue;
            for (int p = 0; p < 3; p++) begin
                ra = (p == 1) ? 5'd2 : 5'd1;
                rb = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
                emit(enc_i(12'd0, 5'd0, 3'd0, 5'd6, OPC_OPIMM));
                emit(enc_b(13'd8, rb, ra, 3'(f3)));
                emit(enc_i(12'd1, 5'd0, 3'd0, 5'd6, OPC_OPIMM));
                store_word(5'd6, branch_rule(3'(f3), regv[ra], regv[rb]) ? 32'd0 : 32'd1);
            end
        end
        link = cur_pc() + 32'd4;
        emit(enc_j(21'd8, 5'd7));
        emit(32'h0000_0000);   // Skipped, illegal
        store_word(5'd7, link);
        target = BASE_PC + 32'(4 * (pidx + 4));
        load_const(5'd9, target - 32'd3);   // Bit 0 set, cleared by jalr
        link = cur_pc() + 32'd4;
        emit(enc_i(12'd4, 5'd9, 3'd0, 5'd11, OPC_JALR));
        emit(32'h0000_0000);
        store_word(5'd11, link);
        emit(enc_i(12'd0, 5'd0, FUNCT3_HALT, 5'd0, OPC_SYSTEM));
        reset_dut();
        wait_stop();
        check_value(32'd1, {31'b0, hlt && !error});
        check_words();
        end_test();
    endtask

    task automatic test_mem();
        logic [31:0] v;
        logic [11:0] a;
        begin_test("memory");
        rand_ready = 1'b1;
        start_program();
        for (int i = 0; i < 6; i++) begin
            seed = lcg_next(seed);
            v = seed;
            load_const(5'd1, v);
            a = st_off;
            store_word(5'd1, v);
            emit(enc_i(a, 5'd10, 3'd2, 5'd2, OPC_LOAD));
            store_word(5'd2, v);
        end
        emit(enc_i(12'd0, 5'd0, FUNCT3_HALT, 5'd0, OPC_SYSTEM));
        reset_dut();
        wait_stop();
        check_value(32'd1, {31'b0, hlt && !error});
        check_words();
        rand_ready = 1'b0;
        end_test();
    endtask

    task automatic test_halt();
        begin_test("halt");
        rand_ready = 1'b0;
        start_program();
        emit(enc_i(12'd0, 5'd0, FUNCT3_HALT, 5'd0, OPC_SYSTEM));
        reset_dut();
        wait_stop();
        check_value(32'd2, {30'b0, hlt, error});
        repeat (20) begin
            @(posedge main_clk);
            assert (nrd && nwr == 4'hf) else begin
                $display("%s: bus active after halt", cur_test);
                errors = errors + 1;
            end
        end
        end_test();
    endtask

    task automatic test_illegal();
        begin_test("illegal");
        rand_ready = 1'b0;
        start_program();
        emit(32'h0000_007f);
        reset_dut();
        wait_stop();
        check_value(32'd1, {30'b0, hlt, error});
        end_test();
    endtask

    task automatic test_misaligned();
        begin_test("misaligned");
        rand_ready = 1'b0;
        start_program();
        load_const(5'd1, DATA_BASE + 32'd2);
        emit(enc_i(12'd0, 5'd1, 3'd2, 5'd2, OPC_LOAD));
        emit(enc_i(12'd0, 5'd0, FUNCT3_HALT, 5'd0, OPC_SYSTEM));
        reset_dut();
        wait_stop();
        check_value(32'd1, {30'b0, hlt, error});
        @(posedge main_clk);
        assert (!bad_access) else begin
            $display("%s: bus access at a misaligned address", cur_test);
            errors = errors + 1;
        end
        end_test();
    endtask

    initial begin
        nreset       = 1'b0;
        ready        = 1'b1;
        rand_ready   = 1'b0;
        seed         = 32'he1c2_30d2;
        rdy_state    = 32'he1c2_30d2;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        write_count  = 0;
        bad_access   = 1'b0;
        cur_test     = "init";
        test_reset();
        test_alu();
        test_branch();
        test_mem();
        test_halt();
        test_illegal();
        test_misaligned();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: source/tiny32.sv
module tiny32 #(
    parameter logic [tiny32_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          main_clk,
    input  logic                          nreset,
    output logic [tiny32_pkg::XLEN-1:0]   address,
    input  logic [tiny32_pkg::XLEN-1:0]   data_in,
    output logic [tiny32_pkg::XLEN-1:0]   data_out,
    output logic                          nrd,
    output logic [3:0]                    nwr,
    input  logic                          ready,
    output logic                          hlt,
    output logic                          error
);
    import tiny32_pkg::*;

    stage_e                stage;
    logic [XLEN-1:0]       pc;
    decoded_t              dec;
    logic                  rd_en;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    bus_req_t              req;
    logic [XLEN-1:0]       next_pc;
    logic                  fault;
    logic                  halt_req;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]       wb_data;
    logic                  stopped;

    assign rd_en   = (stage == STAGE_FETCH) && ready;   // Same edge as decode
    assign stopped = hlt || error;

    tiny32_decoder u_decoder (
        .main_clk (main_clk),
        .nreset   (nreset),
        .stage    (stage),
        .ready    (ready),
        .data_in  (data_in),
        .dec      (dec)
    );

    tiny32_regfile u_regfile (
        .main_clk (main_clk),
        .rd_en    (rd_en),
        .rs1_addr (data_in[19:15]),
        .rs2_addr (data_in[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    tiny32_execute u_execute (
        .main_clk (main_clk),
        .nreset   (nreset),
        .stage    (stage),
        .ready    (ready),
        .pc       (pc),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .data_in  (data_in),
        .req      (req),
        .next_pc  (next_pc),
        .fault    (fault),
        .halt_req (halt_req),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    tiny32_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_sequencer (
        .main_clk (main_clk),
        .nreset   (nreset),
        .ready    (ready),
        .dec      (dec),
        .fault    (fault),
        .halt_req (halt_req),
        .next_pc  (next_pc),
        .stage    (stage),
        .pc       (pc),
        .hlt      (hlt),
        .error    (error)
    );

    tiny32_bus_unit u_bus_unit (
        .main_clk (main_clk),
        .nreset   (nreset),
        .stage    (stage),
        .pc       (pc),
        .req      (req),
        .stopped  (stopped),
        .address  (address),
        .nrd      (nrd),
        .nwr      (nwr),
        .data_out (data_out)
    );

endmodule

// File: source/tiny32_bus_unit.sv
module tiny32_bus_unit (
    input  logic                          main_clk,
    input  logic                          nreset,
    input  tiny32_pkg::stage_e            stage,
    input  logic [tiny32_pkg::XLEN-1:0]   pc,
    input  tiny32_pkg::bus_req_t          req,
    input  logic                          stopped,
    output logic [tiny32_pkg::XLEN-1:0]   address,
    output logic                          nrd,
    output logic [3:0]                    nwr,
    output logic [tiny32_pkg::XLEN-1:0]   data_out
);
    import tiny32_pkg::*;

    bus_req_t req_q;
    logic     in_mem;

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            req_q.is_load  <= 1'b0;
            req_q.is_store <= 1'b0;
        end else if (stage == STAGE_EXEC) begin
            req_q <= req;   // Held for all of STAGE_MEM
        end
    end

    assign in_mem = (stage == STAGE_MEM) && !stopped;

    // ********************
    assign address  = (stage == STAGE_MEM) ? req_q.addr : pc;
    assign nrd      = !((!stopped && stage == STAGE_FETCH) || (in_mem && req_q.is_load));
    assign nwr      = (in_mem && req_q.is_store) ? 4'b0000 : 4'b1111;   // Word stores only
    assign data_out = req_q.wdata;

endmodule

// File: source/tiny32_decoder.sv
module tiny32_decoder (
    input  logic                          main_clk,
    input  logic                          nreset,
    input  tiny32_pkg::stage_e            stage,
    input  logic                          ready,
    input  logic [tiny32_pkg::XLEN-1:0]   data_in,
    output tiny32_pkg::decoded_t          dec
);
    import tiny32_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      func3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    decoded_t        dec_next;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt, input logic is_reg);
        case (f3)
            3'd0:    alu_sel = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'd1:    alu_sel = ALU_SLL;
            3'd2:    alu_sel = ALU_SLT;
            3'd3:    alu_sel = ALU_SLTU;
            3'd4:    alu_sel = ALU_XOR;
            3'd5:    alu_sel = alt ? ALU_SRA : ALU_SRL;   // Bit 30 also for srai
            3'd6:    alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    assign opcode = data_in[6:0];
    assign func3  = data_in[14:12];

    assign imm_i = {{20{data_in[31]}}, data_in[31:20]};
    assign imm_s = {{20{data_in[31]}}, data_in[31:25], data_in[11:7]};
    assign imm_b = {{19{data_in[31]}}, data_in[31], data_in[7], data_in[30:25],
                    data_in[11:8], 1'b0};
    assign imm_u = {data_in[31:12], 12'h000};
    assign imm_j = {{11{data_in[31]}}, data_in[31], data_in[19:12], data_in[20],
                    data_in[30:21], 1'b0};

    always_comb begin
        dec_next         = '0;
        dec_next.kind    = KIND_ILLEGAL;
        dec_next.alu_op  = ALU_ADD;
        dec_next.func3   = func3;
        dec_next.rd      = data_in[11:7];
        dec_next.rs1     = data_in[19:15];
        dec_next.rs2     = data_in[24:20];
        dec_next.imm     = imm_i;
        case (opcode)
            OPC_OP: begin
                dec_next.kind   = KIND_ALU;
                dec_next.alu_op = alu_sel(func3, data_in[30], 1'b1);
            end
            OPC_OPIMM: begin
                dec_next.kind    = KIND_ALU;
                dec_next.use_imm = 1'b1;
                dec_next.alu_op  = alu_sel(func3, data_in[30], 1'b0);
            end
            OPC_LUI: begin
                dec_next.kind = KIND_LUI;
                dec_next.imm  = imm_u;
            end
            OPC_AUIPC: begin
                dec_next.kind = KIND_AUIPC;
                dec_next.imm  = imm_u;
            end
            OPC_JAL: begin
                dec_next.kind = KIND_JAL;
                dec_next.imm  = imm_j;
            end
            OPC_JALR: begin
                dec_next.kind    = KIND_JALR;
                dec_next.use_imm = 1'b1;
            end
            OPC_BRANCH: begin
                dec_next.kind   = KIND_BRANCH;
                dec_next.alu_op = ALU_SUB;
                dec_next.imm    = imm_b;
            end
            OPC_LOAD: begin
                dec_next.kind    = KIND_LOAD;
                dec_next.use_imm = 1'b1;
            end
            OPC_STORE: begin
                dec_next.kind    = KIND_STORE;
                dec_next.use_imm = 1'b1;
                dec_next.imm     = imm_s;
            end
            OPC_SYSTEM: begin
                dec_next.kind = (func3 == FUNCT3_HALT) ? KIND_HALT : KIND_ILLEGAL;
            end
            default: begin
                dec_next.kind = KIND_ILLEGAL;
            end
        endcase
    end

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            dec <= '0;
        end else if (stage == STAGE_FETCH && ready) begin   // Word valid with ready
            dec <= dec_next;
        end
    end

endmodule

// File: source/tiny32_execute.sv
module tiny32_execute (
    input  logic                                main_clk,
    input  logic                                nreset,
    input  tiny32_pkg::stage_e                  stage,
    input  logic                                ready,
    input  logic [tiny32_pkg::XLEN-1:0]         pc,
    input  tiny32_pkg::decoded_t                dec,
    input  logic [tiny32_pkg::XLEN-1:0]         rs1_data,
    input  logic [tiny32_pkg::XLEN-1:0]         rs2_data,
    input  logic [tiny32_pkg::XLEN-1:0]         data_in,
    output tiny32_pkg::bus_req_t                req,
    output logic [tiny32_pkg::XLEN-1:0]         next_pc,
    output logic                                fault,
    output logic                                halt_req,
    output logic                                wb_en,
    output logic [tiny32_pkg::REG_ADDR_W-1:0]   wb_addr,
    output logic [tiny32_pkg::XLEN-1:0]         wb_data
);
    import tiny32_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN:0]   diff;          // Carry in top bit
    logic            unsigned_lt;
    logic            signed_lt;
    logic            br_taken;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] pc_rel;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] result_q;
    logic            is_mem;
    logic            writes_rd;
    logic            addr_misaligned;
    logic            retire;

    // ******************** ALU
    assign op_b        = dec.use_imm ? dec.imm : rs2_data;
    assign diff        = {1'b0, rs1_data} - {1'b0, op_b};
    assign unsigned_lt = diff[XLEN];
    assign signed_lt   = (rs1_data[XLEN-1] != op_b[XLEN-1]) ? rs1_data[XLEN-1] : unsigned_lt;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = rs1_data + op_b;
            ALU_SUB:  alu_res = diff[XLEN-1:0];
            ALU_SLL:  alu_res = rs1_data << op_b[4:0];
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, signed_lt};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, unsigned_lt};
            ALU_XOR:  alu_res = rs1_data ^ op_b;
            ALU_SRL:  alu_res = rs1_data >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(rs1_data) >>> op_b[4:0];
            ALU_OR:   alu_res = rs1_data | op_b;
            ALU_AND:  alu_res = rs1_data & op_b;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (dec.func3)
            3'd0:    br_taken = (diff[XLEN-1:0] == '0);
            3'd1:    br_taken = (diff[XLEN-1:0] != '0);
            3'd4:    br_taken = signed_lt;
            3'd5:    br_taken = !signed_lt;
            3'd6:    br_taken = unsigned_lt;
            3'd7:    br_taken = !unsigned_lt;
            default: br_taken = 1'b0;
        endcase
    end

    // ******************** PC and result
    assign pc_plus_4 = pc + XLEN'(4);
    assign pc_rel    = pc + dec.imm;   // Branch, jal and auipc

    always_comb begin
        case (dec.kind)
            KIND_JAL:    next_pc = pc_rel;
            KIND_JALR:   next_pc = {alu_res[XLEN-1:1], 1'b0};
            KIND_BRANCH: next_pc = br_taken ? pc_rel : pc_plus_4;
            default:     next_pc = pc_plus_4;
        endcase
    end

    always_comb begin
        case (dec.kind)
            KIND_LUI:   result = dec.imm;
            KIND_AUIPC: result = pc_rel;
            KIND_JAL,
            KIND_JALR:  result = pc_plus_4;   // Link value
            default:    result = alu_res;
        endcase
    end

    assign is_mem          = (dec.kind == KIND_LOAD) || (dec.kind == KIND_STORE);
    assign addr_misaligned = is_mem && (alu_res[1:0] != 2'b00);
    assign fault           = (dec.kind == KIND_ILLEGAL) || addr_misaligned ||
                             (next_pc[1:0] != 2'b00);
    assign halt_req        = (dec.kind == KIND_HALT);

    assign req.addr     = alu_res;
    assign req.wdata    = rs2_data;
    assign req.is_load  = (dec.kind == KIND_LOAD) && !fault;
    assign req.is_store = (dec.kind == KIND_STORE) && !fault;

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            result_q <= '0;
        end else if (stage == STAGE_EXEC) begin
            result_q <= result;
        end
    end

    // ******************** Writeback
    assign writes_rd = (dec.kind == KIND_ALU) || (dec.kind == KIND_LUI) ||
                       (dec.kind == KIND_AUIPC) || (dec.kind == KIND_JAL) ||
                       (dec.kind == KIND_JALR) || (dec.kind == KIND_LOAD);
    assign retire    = (stage == STAGE_MEM) && (ready || !is_mem);
    assign wb_en     = retire && writes_rd;
    assign wb_addr   = dec.rd;
    assign wb_data   = (dec.kind == KIND_LOAD) ? data_in : result_q;

endmodule

// File: source/tiny32_pkg.sv
package tiny32_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ********************
    typedef enum logic [1:0] {
        STAGE_ADDR,
        STAGE_FETCH,
        STAGE_EXEC,
        STAGE_MEM
    } stage_e;

    typedef enum logic [3:0] {
        KIND_ALU,
        KIND_LUI,
        KIND_AUIPC,
        KIND_JAL,
        KIND_JALR,
        KIND_BRANCH,
        KIND_LOAD,
        KIND_STORE,
        KIND_HALT,
        KIND_ILLEGAL
    } instr_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // ********************
    localparam logic [6:0] OPC_LOAD   = 7'd3;
    localparam logic [6:0] OPC_SYSTEM = 7'd11;   // Custom opcode, only halt used
    localparam logic [6:0] OPC_OPIMM  = 7'd19;
    localparam logic [6:0] OPC_AUIPC  = 7'd23;
    localparam logic [6:0] OPC_STORE  = 7'd35;
    localparam logic [6:0] OPC_OP     = 7'd51;
    localparam logic [6:0] OPC_LUI    = 7'd55;
    localparam logic [6:0] OPC_BRANCH = 7'd99;
    localparam logic [6:0] OPC_JALR   = 7'd103;
    localparam logic [6:0] OPC_JAL    = 7'd111;

    localparam logic [2:0] FUNCT3_HALT = 3'd2;

    typedef struct packed {
        instr_kind_e           kind;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [2:0]            func3;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;     // Sign extended, shaped per kind
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            is_load;
        logic            is_store;
    } bus_req_t;

endpackage

// File: source/tiny32_regfile.sv
module tiny32_regfile (
    input  logic                                main_clk,
    input  logic                                rd_en,
    input  logic [tiny32_pkg::REG_ADDR_W-1:0]   rs1_addr,
    input  logic [tiny32_pkg::REG_ADDR_W-1:0]   rs2_addr,
    output logic [tiny32_pkg::XLEN-1:0]         rs1_data,
    output logic [tiny32_pkg::XLEN-1:0]         rs2_data,
    input  logic                                wb_en,
    input  logic [tiny32_pkg::REG_ADDR_W-1:0]   wb_addr,
    input  logic [tiny32_pkg::XLEN-1:0]         wb_data
);
    import tiny32_pkg::*;

    logic [XLEN-1:0] regs [1:31];   // x0 not stored

    always_ff @(posedge main_clk) begin
        if (rd_en) begin
            rs1_data <= (rs1_addr == '0) ? '0 : regs[rs1_addr];
            rs2_data <= (rs2_addr == '0) ? '0 : regs[rs2_addr];
        end
    end

    always_ff @(posedge main_clk) begin
        if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

// File: source/tiny32_sequencer.sv
module tiny32_sequencer #(
    parameter logic [tiny32_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          main_clk,
    input  logic                          nreset,
    input  logic                          ready,
    input  tiny32_pkg::decoded_t          dec,
    input  logic                          fault,
    input  logic                          halt_req,
    input  logic [tiny32_pkg::XLEN-1:0]   next_pc,
    output tiny32_pkg::stage_e            stage,
    output logic [tiny32_pkg::XLEN-1:0]   pc,
    output logic                          hlt,
    output logic                          error
);
    import tiny32_pkg::*;

    logic mem_access;

    assign mem_access = (dec.kind == KIND_LOAD) || (dec.kind == KIND_STORE);

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            stage <= STAGE_ADDR;
            pc    <= RESET_PC;
            hlt   <= 1'b0;
            error <= 1'b0;
        end else if (!(hlt || error)) begin   // Frozen in STAGE_ADDR once stopped
            case (stage)
                STAGE_ADDR: begin
                    stage <= STAGE_FETCH;
                end
                STAGE_FETCH: begin
                    if (ready) begin
                        stage <= STAGE_EXEC;
                    end
                end
                STAGE_EXEC: begin
                    if (fault) begin
                        error <= 1'b1;
                        stage <= STAGE_ADDR;
                    end else if (halt_req) begin
                        hlt   <= 1'b1;
                        stage <= STAGE_ADDR;
                    end else begin
                        stage <= STAGE_MEM;
                    end
                end
                STAGE_MEM: begin
                    if (ready || !mem_access) begin   // Retire
                        pc    <= next_pc;
                        stage <= STAGE_ADDR;
                    end
                end
                default: begin
                    stage <= STAGE_ADDR;
                end
            endcase
        end
    end

endmodule
